//--- source/beeb_params.svh
// beeb host glue constants
// memory geometry, bank counts and mouse axis limits
`ifndef BEEB_PARAMS_SVH
`define BEEB_PARAMS_SVH

// ==================================================
// memory map
// ==================================================
// core external address, bit 18 picks ram
`define BEEB_ADDR_W 19
// 16 KB bank offset
`define BEEB_BANK_OFS_W 14
// physical rom banks, model b plus master
`define BEEB_ROM_BANKS 14
`define BEEB_ROM_BYTES 229376
`define BEEB_RAM_BYTES 212992

// ==================================================
// mouse as joystick
// ==================================================
// clamp per packet
`define BEEB_MOUSE_STEP 10
`define BEEB_POS_MIN (-128)
`define BEEB_POS_MAX 127
// core analog channel width
`define BEEB_AXIS_W 12

`endif

//--- source/beeb_pkg.sv
// beeb host glue types
// address views, host settings, mouse packet and joystick channel
`include "beeb_params.svh"

package beeb_pkg;

	// ==================================================
	// core external address
	// ==================================================
	// rom side: slot selects a 16 KB window
	typedef struct packed {
		logic                                       ram;
		logic [`BEEB_ADDR_W-`BEEB_BANK_OFS_W-2:0] slot;
		logic [`BEEB_BANK_OFS_W-1:0]               offset;
	} mem_rom_view_s;

	// ram side: flat byte index
	typedef struct packed {
		logic                    ram;
		logic [`BEEB_ADDR_W-2:0] index;
	} mem_ram_view_s;

	// same word, decoded per target store
	typedef union packed {
		mem_rom_view_s rom_view;
		mem_ram_view_s ram_view;
	} mem_addr_u;

	// ==================================================
	// host side
	// ==================================================
	typedef struct packed {
		logic model_master;
		logic mouse_joy_en;
		logic swap_joy;
	} host_cfg_s;

	// one load beat from the host download
	typedef struct packed {
		logic [`BEEB_ADDR_W-2:0] addr;
		logic [7:0]              data;
		logic                    wr;
	} rom_load_s;

	// relative motion, toggle flips per packet
	typedef struct packed {
		logic              toggle;
		logic signed [8:0] dx;
		logic signed [8:0] dy;
		logic [1:0]        buttons;
	} mouse_pkt_s;

	// one core analog joystick channel
	typedef struct packed {
		logic [`BEEB_AXIS_W-1:0] x;
		logic [`BEEB_AXIS_W-1:0] y;
		logic                    fire_n;
	} joy_axis_s;

endpackage

//--- source/beeb_settings.sv
// host settings register
// options apply at once, model select waits for a core reset request
module beeb_settings
	import beeb_pkg::*;
(
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      cfg_wr,
	input  host_cfg_s cfg,
	input  logic      core_reset_req,
	output host_cfg_s settings
);

	// last word written by the host
	host_cfg_s pending_q;
	// model actually seen by the core
	logic      model_q;
	logic      model_next;

	// ==================================================
	// pending host word
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pending_q <= '0;
		end else if (cfg_wr) begin
			pending_q <= cfg;
		end
	end

	// a write in the reset cycle itself wins
	assign model_next = cfg_wr ? cfg.model_master : pending_q.model_master;

	// ==================================================
	// applied model
	// ==================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			model_q <= 1'b0;
		end else if (core_reset_req) begin
			model_q <= model_next;
		end
	end

	always_comb begin
		settings.model_master = model_q;
		settings.mouse_joy_en = pending_q.mouse_joy_en;
		settings.swap_joy     = pending_q.swap_joy;
	end

	// model only moves across a core reset request
	a_model_at_reset_only: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		!$past(core_reset_req) |-> $stable(model_q)
	) else $error("model select changed outside core reset request");

endmodule

//--- source/rom_bank_map.sv
// rom store with host load port
// maps core slot to a physical 16 KB bank per model
`include "beeb_params.svh"

module rom_bank_map
	import beeb_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       model_master,
	input  logic       host_reset,
	input  rom_load_s  rom_load,
	input  mem_addr_u  mem_addr,
	output logic [7:0] rdata
);

	localparam int BANK_W = $clog2(`BEEB_ROM_BANKS);

	logic [7:0]              rom_mem [`BEEB_ROM_BYTES];
	logic [BANK_W-1:0]       bank;
	logic                    mapped;
	logic [`BEEB_ADDR_W-2:0] phys_addr;
	logic [7:0]              rom_q;
	logic                    mapped_q;

	// ==================================================
	// bank decode
	// ==================================================
	// slot = {group, position}
	always_comb begin
		bank   = '0;
		mapped = 1'b1;
		case ({model_master, mem_addr.rom_view.slot})
			// model b: os, mmfs, ram master, basic
			5'b0_01_00: bank = 4'd0;
			5'b0_10_00: bank = 4'd1;
			5'b0_11_10: bank = 4'd2;
			5'b0_11_11: bank = 4'd3;
			// master: adfs, mmfs, mos
			5'b1_00_10: bank = 4'd4;
			5'b1_00_11: bank = 4'd5;
			5'b1_01_00: bank = 4'd6;
			// dfs, viewsheet, edit
			5'b1_10_01: bank = 4'd7;
			5'b1_10_10: bank = 4'd8;
			5'b1_10_11: bank = 4'd9;
			// basic, adfs, view, terminal
			5'b1_11_00: bank = 4'd10;
			5'b1_11_01: bank = 4'd11;
			5'b1_11_10: bank = 4'd12;
			5'b1_11_11: bank = 4'd13;
			default: begin
				bank   = '0;
				mapped = 1'b0;
			end
		endcase
	end

	// bank * 16K + offset
	assign phys_addr = {bank, mem_addr.rom_view.offset};

	// ==================================================
	// store
	// ==================================================
	// host download, raw address, only while host holds reset
	always_ff @(posedge clk_sys) begin
		if (rom_load.wr && host_reset) begin
			rom_mem[rom_load.addr] <= rom_load.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		rom_q <= rom_mem[phys_addr];
	end

	// mapped flag follows the read by one cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mapped_q <= 1'b0;
		end else begin
			mapped_q <= mapped;
		end
	end

	// empty slots read as zero
	assign rdata = mapped_q ? rom_q : 8'h00;

	// loads come only during host reset, inside the store
	a_load_in_reset: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		rom_load.wr |-> host_reset && (rom_load.addr < `BEEB_ROM_BYTES)
	) else $error("rom load strobe outside host reset or store");

endmodule

//--- source/ext_ram.sv
// external byte ram
// writes on the falling write strobe, registered read
`include "beeb_params.svh"

module ext_ram
	import beeb_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  mem_addr_u  mem_addr,
	input  logic       mem_we_n,
	input  logic [7:0] wdata,
	output logic [7:0] rdata
);

	logic [7:0] ram_mem [`BEEB_RAM_BYTES];
	// strobe from last cycle
	logic       we_n_q;
	logic       wr_en;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	// one write per strobe, ram side only
	assign wr_en = mem_addr.ram_view.ram && we_n_q && !mem_we_n;

	// ==================================================
	// store
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			ram_mem[mem_addr.ram_view.index] <= wdata;
		end
	end

	always_ff @(posedge clk_sys) begin
		rdata <= ram_mem[mem_addr.ram_view.index];
	end

	// core must not write past the populated ram
	a_write_in_range: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		wr_en |-> (mem_addr.ram_view.index < `BEEB_RAM_BYTES)
	) else $error("ram write beyond store");

endmodule

//--- source/mouse_joystick.sv
// mouse as joystick
// absolute mouse position and joy2 mapped to the two core analog channels
`include "beeb_params.svh"

module mouse_joystick
	import beeb_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  host_cfg_s   settings,
	input  logic        core_reset_req,
	input  mouse_pkt_s  mouse,
	input  logic [15:0] joy1_analog,
	input  logic [15:0] joy2_analog,
	input  logic [15:0] joy1_buttons,
	input  logic [15:0] joy2_buttons,
	output joy_axis_s   joy_a,
	output joy_axis_s   joy_b
);

	localparam logic signed [8:0] STEP    = `BEEB_MOUSE_STEP;
	localparam logic signed [8:0] POS_MIN = `BEEB_POS_MIN;
	localparam logic signed [8:0] POS_MAX = `BEEB_POS_MAX;

	logic              toggle_q;
	// mouse has taken over channel a
	logic              emu_q;
	logic signed [8:0] pos_x_q;
	logic signed [8:0] pos_y_q;
	logic signed [8:0] dx;
	logic signed [8:0] dy;
	logic signed [8:0] dx_c;
	logic signed [8:0] dy_c;
	logic signed [8:0] nx;
	logic signed [8:0] ny;
	logic              clear;
	joy_axis_s         src_a;
	joy_axis_s         src_b;

	// signed 8-bit stick value to core channel
	function automatic logic [`BEEB_AXIS_W-1:0] conv_axis(input logic [7:0] v);
		logic [7:0] c;
		c = 8'hff - {~v[7], v[6:0]};
		return {c, c[7:4]};
	endfunction

	// ==================================================
	// position tracking
	// ==================================================
	assign dx    = mouse.dx;
	assign dy    = mouse.dy;
	assign dx_c  = (dx > STEP) ? STEP : (dx < -STEP) ? -STEP : dx;
	assign dy_c  = (dy > STEP) ? STEP : (dy < -STEP) ? -STEP : dy;
	// screen y runs against mouse y
	assign nx    = pos_x_q + dx_c;
	assign ny    = pos_y_q - dy_c;
	assign clear = (|joy1_buttons) || core_reset_req || !settings.mouse_joy_en;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			emu_q    <= 1'b0;
			pos_x_q  <= '0;
			pos_y_q  <= '0;
		end else begin
			toggle_q <= mouse.toggle;
			if (clear) begin
				emu_q   <= 1'b0;
				pos_x_q <= '0;
				pos_y_q <= '0;
			end else if (toggle_q != mouse.toggle) begin
				emu_q   <= 1'b1;
				pos_x_q <= (nx < POS_MIN) ? POS_MIN : (nx > POS_MAX) ? POS_MAX : nx;
				pos_y_q <= (ny < POS_MIN) ? POS_MIN : (ny > POS_MAX) ? POS_MAX : ny;
			end
		end
	end

	// ==================================================
	// channel sources and routing
	// ==================================================
	always_comb begin
		src_a.x      = conv_axis(emu_q ? pos_x_q[7:0] : joy1_analog[7:0]);
		src_a.y      = conv_axis(emu_q ? pos_y_q[7:0] : joy1_analog[15:8]);
		src_a.fire_n = ~(emu_q ? |mouse.buttons : joy1_buttons[4]);
		src_b.x      = conv_axis(joy2_analog[7:0]);
		src_b.y      = conv_axis(joy2_analog[15:8]);
		src_b.fire_n = ~joy2_buttons[4];
	end

	assign joy_a = settings.swap_joy ? src_b : src_a;
	assign joy_b = settings.swap_joy ? src_a : src_b;

	a_pos_in_limits: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		(pos_x_q >= POS_MIN) && (pos_x_q <= POS_MAX) &&
		(pos_y_q >= POS_MIN) && (pos_y_q <= POS_MAX)
	) else $error("mouse position out of limits");

endmodule

//--- source/beeb_host_top.sv
// beeb host glue top
// settings, rom and ram stores and mouse joystick around the core bus
module beeb_host_top
	import beeb_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        cfg_wr,
	input  host_cfg_s   cfg,
	input  logic        host_reset,
	input  rom_load_s   rom_load,
	input  logic        core_reset_req,
	input  mem_addr_u   mem_addr,
	input  logic        mem_we_n,
	input  logic [7:0]  mem_wdata,
	output logic [7:0]  mem_rdata,
	input  mouse_pkt_s  mouse,
	input  logic [15:0] joy1_analog,
	input  logic [15:0] joy2_analog,
	input  logic [15:0] joy1_buttons,
	input  logic [15:0] joy2_buttons,
	output joy_axis_s   joy_a,
	output joy_axis_s   joy_b
);

	host_cfg_s  settings;
	logic [7:0] rom_rdata;
	logic [7:0] ram_rdata;
	// target of the read now in flight
	logic       ram_sel_q;

	beeb_settings settings_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.cfg_wr         (cfg_wr),
		.cfg            (cfg),
		.core_reset_req (core_reset_req),
		.settings       (settings)
	);

	// ==================================================
	// memory
	// ==================================================
	rom_bank_map rom_i (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.model_master (settings.model_master),
		.host_reset   (host_reset),
		.rom_load     (rom_load),
		.mem_addr     (mem_addr),
		.rdata        (rom_rdata)
	);

	ext_ram ram_i (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.mem_addr (mem_addr),
		.mem_we_n (mem_we_n),
		.wdata    (mem_wdata),
		.rdata    (ram_rdata)
	);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ram_sel_q <= 1'b0;
		end else begin
			ram_sel_q <= mem_addr.ram_view.ram;
		end
	end

	assign mem_rdata = ram_sel_q ? ram_rdata : rom_rdata;

	// ==================================================
	// analog joystick
	// ==================================================
	mouse_joystick joy_i (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.settings       (settings),
		.core_reset_req (core_reset_req),
		.mouse          (mouse),
		.joy1_analog    (joy1_analog),
		.joy2_analog    (joy2_analog),
		.joy1_buttons   (joy1_buttons),
		.joy2_buttons   (joy2_buttons),
		.joy_a          (joy_a),
		.joy_b          (joy_b)
	);

endmodule

//--- dv/beeb_host_tb.sv
// testbench for the beeb host glue
// table of steps over memory map, settings and mouse joystick
`include "beeb_params.svh"

module beeb_host_tb
	import beeb_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum int {
		OP_CFG, OP_ROM_LOAD, OP_CORE_RST, OP_ROM_RD, OP_RAM_WR,
		OP_RAM_RD, OP_MOUSE, OP_JOY, OP_JOY_CHK
	} op_e;

	// operands a b c and repeat count n with expected stick position ex ey
	typedef struct {
		op_e op;
		int  a;
		int  b;
		int  c;
		int  n;
		int  ex;
		int  ey;
	} step_s;

	logic        clk_sys;
	logic        arst_n;
	logic        cfg_wr;
	host_cfg_s   cfg;
	logic        host_reset;
	rom_load_s   rom_load;
	logic        core_reset_req;
	mem_addr_u   mem_addr;
	logic        mem_we_n;
	logic [7:0]  mem_wdata;
	logic [7:0]  mem_rdata;
	mouse_pkt_s  mouse;
	logic [15:0] joy1_analog;
	logic [15:0] joy2_analog;
	logic [15:0] joy1_buttons;
	logic [15:0] joy2_buttons;
	joy_axis_s   joy_a;
	joy_axis_s   joy_b;

	step_s       steps[$];
	// bytes loaded per bank at eight sample offsets
	logic [7:0]  rom_model [`BEEB_ROM_BANKS][8];
	logic [31:0] lfsr_q;
	int          fail_cnt;
	int          budget;
	bit          table_ready;

	beeb_host_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==================================================
	// helpers
	// ==================================================
	task automatic compare_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			fail_cnt++;
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] step_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_rand_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_q = step_lfsr(lfsr_q);
			b = {b[6:0], lfsr_q[0]};
		end
	endtask

	// sample points inside a bank including both ends
	function automatic logic [13:0] rom_offset(input int k);
		case (k)
			0: return 14'h0000;
			1: return 14'h0001;
			2: return 14'h0155;
			3: return 14'h02aa;
			4: return 14'h1000;
			5: return 14'h2001;
			6: return 14'h3ffe;
			default: return 14'h3fff;
		endcase
	endfunction

	// 255 minus offset binary p + 128 with the upper nibble repeated below
	function automatic logic [11:0] axis_code(input int p);
		int         t;
		logic [7:0] c;
		t = 127 - p;
		c = t[7:0];
		return {c, c[7:4]};
	endfunction

	function automatic void add_step(op_e op, int a, int b, int c, int n, int ex, int ey);
		steps.push_back('{op, a, b, c, n, ex, ey});
	endfunction

	// ==================================================
	// bus operations
	// ==================================================
	task automatic load_rom();
		logic [7:0]  d;
		logic [17:0] la;
		for (int bank = 0; bank < `BEEB_ROM_BANKS; bank++) begin
			for (int k = 0; k < 8; k++) begin
				next_rand_byte(d);
				la = {bank[3:0], rom_offset(k)};
				rom_model[bank][k] = d;
				@(posedge clk_sys);
				rom_load <= {la, d, 1'b1};
			end
		end
		@(posedge clk_sys);
		rom_load.wr <= 1'b0;
		host_reset <= 1'b0;
	endtask

	task automatic read_mem(input logic [18:0] addr, input logic [7:0] exp);
		@(posedge clk_sys);
		mem_addr <= addr;
		// one cycle read latency
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_val("mem_rdata", {24'b0, mem_rdata}, {24'b0, exp});
	endtask

	task automatic write_ram(input int idx, input int data, input int flag);
		@(posedge clk_sys);
		mem_addr <= {flag[0], idx[17:0]};
		mem_wdata <= data[7:0];
		mem_we_n <= 1'b1;
		@(posedge clk_sys);
		mem_we_n <= 1'b0;
		// data moves while strobe stays low
		@(posedge clk_sys);
		mem_wdata <= ~data[7:0];
		@(posedge clk_sys);
		@(posedge clk_sys);
		mem_we_n <= 1'b1;
	endtask

	task automatic send_mouse(input int dx, input int dy, input int btn, input int n);
		repeat (n) begin
			@(posedge clk_sys);
			mouse.dx <= dx[8:0];
			mouse.dy <= dy[8:0];
			mouse.buttons <= btn[1:0];
			mouse.toggle <= ~mouse.toggle;
			@(posedge clk_sys);
		end
	endtask

	task automatic check_joy(input int which, input int ex, input int ey, input int fire);
		joy_axis_s j;
		string     nm;
		@(negedge clk_sys);
		j = (which == 0) ? joy_a : joy_b;
		nm = (which == 0) ? "joy_a" : "joy_b";
		compare_val({nm, ".x"}, {20'b0, j.x}, {20'b0, axis_code(ex)});
		compare_val({nm, ".y"}, {20'b0, j.y}, {20'b0, axis_code(ey)});
		compare_val({nm, ".fire_n"}, {31'b0, j.fire_n}, {31'b0, fire == 0});
	endtask

	task automatic run_step(input step_s s);
		logic [7:0] exp;
		case (s.op)
			OP_CFG: begin
				@(posedge clk_sys);
				cfg_wr <= 1'b1;
				cfg <= s.a[2:0];
				@(posedge clk_sys);
				cfg_wr <= 1'b0;
			end
			OP_ROM_LOAD: load_rom();
			OP_CORE_RST: begin
				@(posedge clk_sys);
				core_reset_req <= 1'b1;
				@(posedge clk_sys);
				core_reset_req <= 1'b0;
			end
			OP_ROM_RD: begin
				// negative bank marks an empty slot
				exp = 8'h00;
				if (s.c >= 0) begin
					exp = rom_model[s.c][s.b];
				end
				read_mem({1'b0, s.a[3:0], rom_offset(s.b)}, exp);
			end
			OP_RAM_WR: write_ram(s.a, s.b, s.c);
			OP_RAM_RD: read_mem({1'b1, s.a[17:0]}, s.b[7:0]);
			OP_MOUSE: send_mouse(s.a, s.b, s.c, s.n);
			OP_JOY: begin
				@(posedge clk_sys);
				joy1_analog <= s.a[15:0];
				joy2_analog <= s.b[15:0];
				joy1_buttons <= s.c[15:0];
				joy2_buttons <= s.c[31:16];
				@(posedge clk_sys);
			end
			default: check_joy(s.a, s.ex, s.ey, s.c);
		endcase
	endtask

	// ==================================================
	// step table
	// ==================================================
	task automatic build_table();
		// model b slots and then an empty one
		add_step(OP_ROM_LOAD, 0, 0, 0, 112, 0, 0);
		add_step(OP_ROM_RD, 4'b0100, 0, 0, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b1000, 3, 1, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b1110, 7, 2, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b1111, 5, 3, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b0010, 1, -1, 1, 0, 0);
		// master written but not yet applied
		add_step(OP_CFG, 3'b100, 0, 0, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b0100, 4, 0, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b0010, 0, -1, 1, 0, 0);
		add_step(OP_CORE_RST, 0, 0, 0, 1, 0, 0);
		for (int i = 0; i < 10; i++) begin
			add_step(OP_ROM_RD, (i < 3) ? 2 + i : 6 + i, i % 8, 4 + i, 1, 0, 0);
		end
		add_step(OP_ROM_RD, 4'b1000, 2, -1, 1, 0, 0);
		// ram readback and then a write with the flag clear
		add_step(OP_RAM_WR, 'h00123, 'h5a, 1, 1, 0, 0);
		add_step(OP_RAM_RD, 'h00123, 'h5a, 0, 1, 0, 0);
		add_step(OP_RAM_WR, 'h00123, 'h99, 0, 1, 0, 0);
		add_step(OP_RAM_RD, 'h00123, 'h5a, 0, 1, 0, 0);
		add_step(OP_ROM_RD, 4'b0011, 1, 5, 1, 0, 0);
		// mouse on with clamp and saturation
		add_step(OP_CFG, 3'b110, 0, 0, 1, 0, 0);
		add_step(OP_MOUSE, 200, -200, 0, 1, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 0, 1, 10, 10);
		add_step(OP_MOUSE, 250, 250, 0, 14, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 0, 1, 127, -128);
		add_step(OP_MOUSE, -5, -5, 1, 1, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 1, 1, 122, -123);
		add_step(OP_MOUSE, -250, -250, 2, 30, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 1, 1, -128, 127);
		add_step(OP_JOY_CHK, 1, 0, 0, 1, 0, 0);
		// joy1 button takes channel a back
		add_step(OP_JOY, 'h20f0, 0, 'h0000_0010, 1, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 1, 1, -16, 32);
		add_step(OP_JOY, 'h20f0, 'h807f, 'h0010_0000, 1, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 0, 1, -16, 32);
		add_step(OP_JOY_CHK, 1, 0, 1, 1, 127, -128);
		add_step(OP_CFG, 3'b111, 0, 0, 1, 0, 0);
		add_step(OP_JOY_CHK, 0, 0, 1, 1, 127, -128);
		add_step(OP_JOY_CHK, 1, 0, 0, 1, -16, 32);
		// packet ignored with the mouse disabled
		add_step(OP_CFG, 3'b101, 0, 0, 1, 0, 0);
		add_step(OP_MOUSE, 7, 7, 3, 1, 0, 0);
		add_step(OP_JOY_CHK, 1, 0, 0, 1, -16, 32);
	endtask

	initial begin
		arst_n = 1'b0;
		cfg_wr = 1'b0;
		cfg = '0;
		host_reset = 1'b1;
		rom_load = '0;
		core_reset_req = 1'b0;
		mem_addr = '0;
		mem_we_n = 1'b1;
		mem_wdata = 8'h00;
		mouse = '0;
		joy1_analog = '0;
		joy2_analog = '0;
		joy1_buttons = '0;
		joy2_buttons = '0;
		lfsr_q = 32'hab5c;
		fail_cnt = 0;
		build_table();
		budget = 20;
		foreach (steps[i]) begin
			budget += 10 * steps[i].n;
		end
		table_ready = 1'b1;
		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		@(posedge clk_sys);
		if (fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog allows ten cycles per table step and repeat
	initial begin
		wait (table_ready);
		repeat (budget) @(posedge clk_sys);
		$display("Run timed out after %0d cycles before the step table finished", budget);
		$display("Something failed");
		$fatal(1);
	end

endmodule

//--- tb.f
+incdir+source
source/beeb_pkg.sv
source/beeb_settings.sv
source/rom_bank_map.sv
source/ext_ram.sv
source/mouse_joystick.sv
source/beeb_host_top.sv
dv/beeb_host_tb.sv
